/* Bender.yml */
package:
  name: rl_agent

sources:
  - include_dirs:
      - design
    files:
      - design/rl_types_pkg.sv
      - design/rl_bus_pkg.sv
      - design/epsilon_prng.sv
      - design/draw_lfsr.sv
      - design/q_table.sv
      - design/action_selector.sv
      - design/agent_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/agent_chk.sv
      - test/agent_tb.sv

/* design/action_selector.sv */
`default_nettype none

`include "rl_params.svh"

module action_selector (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  rl_types_pkg::epsilon_t  epsilon,
    input  logic [`EPS_WIDTH-1:0]   draw,
    input  logic                    row_valid,
    input  rl_types_pkg::q_row_t    row,
    output logic                    resp_valid,
    output rl_bus_pkg::agent_resp_t resp
);

    // request-cycle epsilon and draw, aligned with the table read
    rl_types_pkg::epsilon_t eps_q;
    logic [`EPS_WIDTH-1:0]  draw_q;

    rl_types_pkg::action_t  greedy_action;
    rl_types_pkg::q_value_t greedy_value;
    rl_types_pkg::q_value_t cand;
    rl_types_pkg::epsilon_t draw_frac;
    logic                   explore;

    always_ff @(posedge clk) begin
        if (req_valid) begin
            eps_q  <= epsilon;
            draw_q <= draw;
        end
    end

    // signed argmax, strict compare so ties keep the lower action
    always_comb begin
        greedy_action = '0;
        greedy_value  = row[0];
        for (int a = 1; a < rl_types_pkg::NUM_ACTIONS; a++) begin
            cand = row[a];
            if (cand > greedy_value) begin
                greedy_value  = cand;
                greedy_action = rl_types_pkg::action_t'(a);
            end
        end
    end

    // uniform fraction in [0,1) against epsilon
    assign draw_frac = rl_types_pkg::epsilon_t'(draw_q[`EPS_FRAC-1:0]);
    assign explore   = draw_frac < eps_q;

    always_ff @(posedge clk) begin
        if (row_valid) begin
            // explore picks the top two draw bits as the action
            resp.action       <= explore ? draw_q[`EPS_WIDTH-1 -: 2] : greedy_action;
            resp.explored     <= explore;
            resp.epsilon      <= eps_q;
            resp.greedy_value <= greedy_value;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= row_valid;
        end
    end

endmodule

`default_nettype wire

/* design/agent_top.sv */
`default_nettype none

`include "rl_params.svh"

module agent_top (
    input  logic                      clk,
    input  logic                      rst,
    input  rl_types_pkg::prng_state_t seed,
    input  logic                      req_valid,
    input  rl_bus_pkg::agent_req_t    req,
    input  logic                      upd_valid,
    input  rl_bus_pkg::q_update_t     upd,
    output logic                      resp_valid,
    output rl_bus_pkg::agent_resp_t   resp
);

    rl_types_pkg::epsilon_t epsilon;
    logic [`EPS_WIDTH-1:0]  draw;
    rl_types_pkg::q_row_t   row;
    logic                   row_valid;

    // epsilon schedule and draw both advance on accepted requests
    epsilon_prng i_epsilon_prng (
        .clk     (clk),
        .rst     (rst),
        .seed    (seed),
        .step    (req_valid),
        .epsilon (epsilon)
    );

    draw_lfsr i_draw_lfsr (
        .clk  (clk),
        .rst  (rst),
        .step (req_valid),
        .draw (draw)
    );

    q_table i_q_table (
        .clk       (clk),
        .rst       (rst),
        .rd_valid  (req_valid),
        .rd_state  (req.state),
        .upd_valid (upd_valid),
        .upd       (upd),
        .row       (row),
        .row_valid (row_valid)
    );

    action_selector i_action_selector (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .epsilon    (epsilon),
        .draw       (draw),
        .row_valid  (row_valid),
        .row        (row),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

`default_nettype wire

/* design/draw_lfsr.sv */
`default_nettype none

`include "rl_params.svh"

module draw_lfsr (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  step,
    output logic [`EPS_WIDTH-1:0] draw
);

    logic [`EPS_WIDTH-1:0] lfsr;
    logic [`EPS_WIDTH-1:0] lfsr_shr;

    assign lfsr_shr = lfsr >> 1;

    // galois form, taps folded in when a one falls out of bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= `DRAW_LFSR_INIT;
        end else if (step) begin
            if (lfsr[0]) begin
                lfsr <= lfsr_shr ^ `DRAW_LFSR_TAPS;
            end else begin
                lfsr <= lfsr_shr;
            end
        end
    end

    assign draw = lfsr;

endmodule

`default_nettype wire

/* design/epsilon_prng.sv */
`default_nettype none

module epsilon_prng (
    input  logic                      clk,
    input  logic                      rst,
    input  rl_types_pkg::prng_state_t seed,
    input  logic                      step,
    output rl_types_pkg::epsilon_t    epsilon
);

    rl_types_pkg::prng_state_t state;
    rl_types_pkg::prng_state_t state_shl;

    // state << 4 kept to five bits leaves only bit 0 in the top place
    assign state_shl = {state[0], 4'b0000};

    // advances once per accepted request, not per clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= seed;
        end else if (step) begin
            state <= (state ^ state_shl) + 5'd3;
        end
    end

    // stepped schedule from 0 up to one half
    always_comb begin
        case (state)
            5'd0, 5'd1:
                epsilon = 24'h000000;
            5'd2, 5'd3:
                epsilon = 24'h000E38;
            5'd4, 5'd5, 5'd6:
                epsilon = 24'h001C71;
            5'd7, 5'd8, 5'd9, 5'd10:
                epsilon = 24'h002AAA;
            5'd11, 5'd12, 5'd13, 5'd14, 5'd15:
                epsilon = 24'h0038E3;
            5'd16, 5'd17, 5'd18, 5'd19, 5'd20:
                epsilon = 24'h00471C;
            5'd21, 5'd22, 5'd23, 5'd24:
                epsilon = 24'h005555;
            5'd25, 5'd26, 5'd27:
                epsilon = 24'h00638E;
            5'd28, 5'd29:
                epsilon = 24'h0071C7;
            default:
                epsilon = 24'h008000;
        endcase
    end

endmodule

`default_nettype wire

/* design/q_table.sv */
`default_nettype none

module q_table (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rd_valid,
    input  rl_types_pkg::env_state_t rd_state,
    input  logic                     upd_valid,
    input  rl_bus_pkg::q_update_t    upd,
    output rl_types_pkg::q_row_t     row,
    output logic                     row_valid
);

    // one row of action values per environment state
    rl_types_pkg::q_row_t mem [rl_types_pkg::NUM_STATES];

    // learning starts from an all-zero table
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < rl_types_pkg::NUM_STATES; s++) begin
                mem[s] <= '0;
            end
        end else if (upd_valid) begin
            mem[upd.state][upd.action] <= upd.value;
        end
    end

    // read sees the row before any write on the same edge
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            row <= mem[rd_state];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_valid <= 1'b0;
        end else begin
            row_valid <= rd_valid;
        end
    end

endmodule

`default_nettype wire

/* design/rl_bus_pkg.sv */
`default_nettype none

package rl_bus_pkg;

    // action request for one environment state
    typedef struct packed {
        rl_types_pkg::env_state_t state;
    } agent_req_t;

    // host write of one learned value
    typedef struct packed {
        rl_types_pkg::env_state_t state;
        rl_types_pkg::action_t    action;
        rl_types_pkg::q_value_t   value;
    } q_update_t;

    // decision returned two cycles after the request
    typedef struct packed {
        rl_types_pkg::action_t  action;
        // set when the action came from the draw instead of the argmax
        logic                   explored;
        // epsilon that was in force for this request
        rl_types_pkg::epsilon_t epsilon;
        // value of the best action in the row
        rl_types_pkg::q_value_t greedy_value;
    } agent_resp_t;

endpackage

`default_nettype wire

/* design/rl_params.svh */
`ifndef RL_PARAMS_SVH
`define RL_PARAMS_SVH

// environment state index width, 16 states
`define NUM_STATES_LOG2 4

// signed Q-value width
`define Q_WIDTH 16

// exploration rate, unsigned fixed point
`define EPS_WIDTH 24

// fraction bits of epsilon, so 0x8000 is one half
`define EPS_FRAC 16

// draw generator reset value
`define DRAW_LFSR_INIT 24'hACE101

// galois tap mask for the right-shifting draw generator
`define DRAW_LFSR_TAPS 24'hE10000

`endif

/* design/rl_types_pkg.sv */
`default_nettype none

`include "rl_params.svh"

package rl_types_pkg;

    // table geometry
    localparam int NUM_STATES  = 1 << `NUM_STATES_LOG2;
    localparam int NUM_ACTIONS = 4;

    // width of the epsilon schedule state
    localparam int PRNG_WIDTH = 5;

    // environment state index
    typedef logic [`NUM_STATES_LOG2-1:0] env_state_t;

    // one of the four actions
    typedef logic [1:0] action_t;

    // learned action value, two's complement
    typedef logic signed [`Q_WIDTH-1:0] q_value_t;

    // exploration rate, EPS_FRAC fraction bits
    typedef logic [`EPS_WIDTH-1:0] epsilon_t;

    // state of the epsilon schedule recurrence
    typedef logic [PRNG_WIDTH-1:0] prng_state_t;

    // all action values of one state, indexed by action
    typedef q_value_t [NUM_ACTIONS-1:0] q_row_t;

endpackage

`default_nettype wire

/* files.f */
+incdir+design
design/rl_types_pkg.sv
design/rl_bus_pkg.sv
design/epsilon_prng.sv
design/draw_lfsr.sv
design/q_table.sv
design/action_selector.sv
design/agent_top.sv
test/agent_chk.sv
test/agent_tb.sv

/* test/agent_chk.sv */
`default_nettype none

module agent_chk (
    input logic                    clk,
    input logic                    rst,
    input logic                    req_valid,
    input logic                    resp_valid,
    input rl_bus_pkg::agent_resp_t resp
);

    // failing assertions seen so far
    int fail_count = 0;

    // fixed two-cycle latency in both directions
    assert property (@(posedge clk) disable iff (rst) req_valid |-> ##2 resp_valid)
        else begin
            $error("request not answered two cycles later");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst) resp_valid |-> $past(req_valid, 2))
        else begin
            $error("response without a request two cycles earlier");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst) resp_valid |-> !$isunknown(resp))
        else begin
            $error("response carries unknown bits");
            fail_count++;
        end

    assert property (@(posedge clk) rst |-> !resp_valid)
        else begin
            $error("response valid during reset");
            fail_count++;
        end

endmodule

bind agent_top agent_chk i_agent_chk (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .resp_valid (resp_valid),
    .resp       (resp)
);

`default_nettype wire

/* test/agent_tb.sv */
`default_nettype none

`include "rl_params.svh"

module agent_tb;

    typedef enum {K_UPD, K_REQ, K_REQ_UPD, K_DRAIN, K_RESET} kind_e;

    typedef struct {
        kind_e                    kind;
        rl_types_pkg::env_state_t state;
        rl_types_pkg::action_t    action;
        rl_types_pkg::q_value_t   value;
        string                    name;
    } stim_t;

    localparam rl_types_pkg::prng_state_t SEED = 5'd9;

    logic                    clk;
    logic                    rst;
    logic                    req_valid;
    rl_bus_pkg::agent_req_t  req;
    logic                    upd_valid;
    rl_bus_pkg::q_update_t   upd;
    logic                    resp_valid;
    rl_bus_pkg::agent_resp_t resp;

    stim_t                   stim [$];
    rl_bus_pkg::agent_resp_t exp_q [$];
    string                   exp_name [$];

    // reference model
    rl_types_pkg::prng_state_t m_prng;
    logic [`EPS_WIDTH-1:0]     m_lfsr;
    rl_types_pkg::q_row_t      shadow [rl_types_pkg::NUM_STATES];
    int                        n_req;
    int                        n_explore;
    int                        n_exploit;

    agent_top i_agent_top (
        .clk        (clk),
        .rst        (rst),
        .seed       (SEED),
        .req_valid  (req_valid),
        .req        (req),
        .upd_valid  (upd_valid),
        .upd        (upd),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    always #2 clk = ~clk;

    // xor with itself shifted left four then add three in five bits
    function automatic rl_types_pkg::prng_state_t next_prng(rl_types_pkg::prng_state_t s);
        rl_types_pkg::prng_state_t shl;
        shl = s << 4;
        return (s ^ shl) + 5'd3;
    endfunction

    function automatic logic [`EPS_WIDTH-1:0] next_lfsr(logic [`EPS_WIDTH-1:0] l);
        return (l >> 1) ^ (l[0] ? `DRAW_LFSR_TAPS : 24'h0);
    endfunction

    // level k of the ten steps is k/18 of one
    function automatic rl_types_pkg::epsilon_t eps_of(rl_types_pkg::prng_state_t s);
        int bounds [10];
        int level;
        bounds = '{2, 4, 7, 11, 16, 21, 25, 28, 30, 32};
        level = 0;
        while (s >= bounds[level]) begin
            level++;
        end
        return rl_types_pkg::epsilon_t'((level << (`EPS_FRAC - 1)) / 9);
    endfunction

    function automatic rl_bus_pkg::agent_resp_t expect_resp(rl_types_pkg::q_row_t r,
                                                            rl_types_pkg::epsilon_t eps,
                                                            logic [`EPS_WIDTH-1:0] d);
        rl_bus_pkg::agent_resp_t e;
        rl_types_pkg::q_value_t  best_v;
        rl_types_pkg::q_value_t  v;
        int                      best;
        best = 0;
        best_v = r[0];
        for (int a = 1; a < 4; a++) begin
            v = r[a];
            if (v > best_v) begin
                best = a;
                best_v = v;
            end
        end
        e.explored = {8'h00, d[15:0]} < eps;
        e.action = e.explored ? d[23:22] : rl_types_pkg::action_t'(best);
        e.epsilon = eps;
        e.greedy_value = best_v;
        return e;
    endfunction

    task automatic stop_run(string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_action(string name, rl_types_pkg::action_t exp,
                                rl_types_pkg::action_t act);
        if (exp !== act) begin
            stop_run($sformatf("Fail %s: action expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            stop_run($sformatf("Fail %s: explored expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_epsilon(string name, rl_types_pkg::epsilon_t exp,
                                 rl_types_pkg::epsilon_t act);
        if (exp !== act) begin
            stop_run($sformatf("Fail %s: epsilon expected 0x%06h, actual 0x%06h",
                               name, exp, act));
        end
    endtask

    task automatic check_q(string name, rl_types_pkg::q_value_t exp,
                           rl_types_pkg::q_value_t act);
        if (exp !== act) begin
            stop_run($sformatf("Fail %s: greedy value expected %0d, actual %0d",
                               name, exp, act));
        end
    endtask

    task automatic add(kind_e kind, int state, int action, int value, string name);
        stim_t t;
        t.kind = kind;
        t.state = rl_types_pkg::env_state_t'(state);
        t.action = rl_types_pkg::action_t'(action);
        t.value = rl_types_pkg::q_value_t'(value);
        t.name = name;
        stim.push_back(t);
    endtask

    task automatic build_table();
        int fixed [3][4];
        fixed = '{'{-5, -3, -3, -7}, '{100, -200, 300, 300}, '{-9, -1, -2, -32768}};
        for (int s = 0; s < 4; s++) begin
            add(K_REQ, s * 5, 0, 0, "zero table");
        end
        add(K_DRAIN, 0, 0, 0, "zero table");
        for (int s = 0; s < 3; s++) begin
            for (int a = 0; a < 4; a++) begin
                add(K_UPD, s + 1, a, fixed[s][a], "fixed update");
            end
        end
        for (int s = 4; s < 12; s++) begin
            for (int a = 0; a < 4; a++) begin
                add(K_UPD, s, a, $urandom, "random fill");
            end
        end
        // bursts of four back-to-back requests
        for (int i = 0; i < 48; i++) begin
            add(K_REQ, i % 16, 0, 0, "epsilon greedy");
            if (i % 4 == 3) begin
                add(K_DRAIN, 0, 0, 0, "epsilon greedy");
            end
        end
        add(K_REQ_UPD, 12, 1, 500, "same cycle write");
        add(K_DRAIN, 0, 0, 0, "same cycle write");
        add(K_REQ, 12, 0, 0, "after write");
        add(K_RESET, 0, 0, 0, "mid-run reset");
        for (int i = 0; i < 4; i++) begin
            add(K_REQ, 2, 0, 0, "after reset");
        end
    endtask

    task automatic drain(string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= 10) begin
                stop_run($sformatf("timeout waiting for responses in %s", name));
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        m_prng = SEED;
        m_lfsr = `DRAW_LFSR_INIT;
        for (int s = 0; s < rl_types_pkg::NUM_STATES; s++) begin
            shadow[s] = '0;
        end
    endtask

    task automatic apply(stim_t t);
        case (t.kind)
            K_DRAIN: drain(t.name);
            K_RESET: begin
                drain(t.name);
                apply_reset();
            end
            default: begin
                req_valid = (t.kind != K_UPD);
                upd_valid = (t.kind != K_REQ);
                req.state = t.state;
                upd.state = t.state;
                upd.action = t.action;
                upd.value = t.value;
                // request sees the row before this cycle's write
                if (req_valid) begin
                    exp_q.push_back(expect_resp(shadow[t.state], eps_of(m_prng), m_lfsr));
                    exp_name.push_back($sformatf("%s #%0d", t.name, n_req));
                    m_prng = next_prng(m_prng);
                    m_lfsr = next_lfsr(m_lfsr);
                    n_req++;
                end
                if (upd_valid) begin
                    shadow[t.state][t.action] = t.value;
                end
                @(negedge clk);
                req_valid = 1'b0;
                upd_valid = 1'b0;
            end
        endcase
    endtask

    always @(negedge clk) begin
        rl_bus_pkg::agent_resp_t e;
        string                   name;
        if (i_agent_top.i_agent_chk.fail_count != 0) begin
            stop_run("a bound handshake assertion failed");
        end else if (!rst && resp_valid) begin
            if (exp_q.size() == 0) begin
                stop_run("a response arrived with no request outstanding");
            end else begin
                e = exp_q.pop_front();
                name = exp_name.pop_front();
                check_action(name, e.action, resp.action);
                check_flag(name, e.explored, resp.explored);
                check_epsilon(name, e.epsilon, resp.epsilon);
                check_q(name, e.greedy_value, resp.greedy_value);
                if (resp.explored) begin
                    n_explore++;
                end else begin
                    n_exploit++;
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        req_valid = 1'b0;
        req = '0;
        upd_valid = 1'b0;
        upd = '0;
        n_req = 0;
        n_explore = 0;
        n_exploit = 0;
        void'($urandom(32'h7ae6_ba35));
        build_table();
        @(negedge clk);
        apply_reset();
        foreach (stim[i]) begin
            apply(stim[i]);
        end
        drain("end of run");
        if (i_agent_top.i_agent_chk.fail_count != 0) begin
            stop_run("a bound handshake assertion failed");
        end else if (n_explore == 0 || n_exploit == 0) begin
            stop_run("requests did not cover both explore and exploit decisions");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
